/* sb_macros.svh */
`ifndef SB_MACROS_SVH
`define SB_MACROS_SVH

// --------------------
// table geometry
// --------------------
// number of table slots, power of two only
`define SB_ENTRIES 8
// slot index width, log2 of SB_ENTRIES
`define SB_TRANS_ID_W 3

// --------------------
// datapath widths
// --------------------
// operand and result width
`define SB_XLEN 32
// integer register index width
`define SB_REG_ADDR_W 5
// integer register count, one clobber bit each
`define SB_NR_REGS 32

`endif

/* sb_pkg.sv */
`include "sb_macros.svh"

package sb_pkg;

  // --------------------
  // width types
  // --------------------
  // result or operand value
  typedef logic [`SB_XLEN-1:0] xlen_t;

  // integer register index
  typedef logic [`SB_REG_ADDR_W-1:0] reg_addr_t;

  // table slot index, doubles as transaction id
  typedef logic [`SB_TRANS_ID_W-1:0] trans_id_t;

  // one bit per integer register
  typedef logic [`SB_NR_REGS-1:0] reg_mask_t;

  // one bit per table entry
  typedef logic [`SB_ENTRIES-1:0] entry_vec_t;

  // --------------------
  // functional units
  // --------------------
  // FU_NONE entries complete without a writeback
  typedef enum logic [1:0] {
    FU_NONE = 2'd0,
    FU_ALU  = 2'd1,
    FU_LSU  = 2'd2,
    FU_MUL  = 2'd3
  } fu_e;

endpackage

/* sb_issue_ctrl.sv */
`timescale 1ns/1ps
`include "sb_macros.svh"

module sb_issue_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  logic              decoded_valid_i,
  input  logic              unresolved_branch_i,
  input  logic              issue_ack_i,
  input  logic              commit_ack_i,
  output logic              issue_valid_o,
  output logic              insert_en_o,
  output logic              sb_full_o,
  output sb_pkg::trans_id_t insert_ptr_o,
  output sb_pkg::trans_id_t commit_ptr_o
);
  import sb_pkg::*;

  // slot that receives the next issued instruction
  trans_id_t insert_ptr_q;
  // oldest slot, the one shown to commit
  trans_id_t commit_ptr_q;
  // entries in flight, never reaches SB_ENTRIES
  trans_id_t cnt_q;
  trans_id_t cnt_d;

  logic full;
  logic insert_en;

  // --------------------
  // issue decision
  // --------------------
  // one slot stays free, so full sits at SB_ENTRIES-1
  assign full = (cnt_q == trans_id_t'(`SB_ENTRIES - 1));

  // hold back on a full table or an open branch
  assign issue_valid_o = decoded_valid_i & ~unresolved_branch_i & ~full;

  // an ack in a flush cycle is dropped
  assign insert_en = issue_ack_i & ~flush_i;

  assign insert_en_o  = insert_en;
  assign sb_full_o    = full;
  assign insert_ptr_o = insert_ptr_q;
  assign commit_ptr_o = commit_ptr_q;

  // --------------------
  // occupancy
  // --------------------
  // insert and commit in the same cycle cancel out
  always_comb begin
    cnt_d = cnt_q;
    if (insert_en && !commit_ack_i) begin
      cnt_d = cnt_q + 1'b1;
    end else if (!insert_en && commit_ack_i) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  // --------------------
  // pointer registers
  // --------------------
  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      insert_ptr_q <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else if (flush_i) begin
      // flush drops everything, a commit ack in this cycle too
      insert_ptr_q <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      if (insert_en) begin
        insert_ptr_q <= insert_ptr_q + 1'b1;
      end
      if (commit_ack_i) begin
        commit_ptr_q <= commit_ptr_q + 1'b1;
      end
      cnt_q <= cnt_d;
    end
  end

endmodule

/* sb_entry_store.sv */
`timescale 1ns/1ps
`include "sb_macros.svh"

module sb_entry_store (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  flush_i,
  input  logic                                  insert_en_i,
  input  logic                                  commit_ack_i,
  input  logic                                  wb_valid_i,
  input  logic                                  wb_ex_i,
  input  sb_pkg::trans_id_t                     insert_ptr_i,
  input  sb_pkg::trans_id_t                     commit_ptr_i,
  input  sb_pkg::trans_id_t                     wb_trans_id_i,
  input  sb_pkg::reg_addr_t                     decoded_rd_i,
  input  sb_pkg::fu_e                           decoded_fu_i,
  input  sb_pkg::xlen_t                         wb_data_i,
  output sb_pkg::entry_vec_t                    valid_o,
  output sb_pkg::entry_vec_t                    done_o,
  output sb_pkg::entry_vec_t                    ex_o,
  output sb_pkg::reg_addr_t [`SB_ENTRIES-1:0]   rd_o,
  output sb_pkg::xlen_t     [`SB_ENTRIES-1:0]   result_o
);
  import sb_pkg::*;

  // per-entry status bits
  entry_vec_t valid_q;
  entry_vec_t valid_d;
  entry_vec_t done_q;
  entry_vec_t done_d;
  entry_vec_t ex_q;
  entry_vec_t ex_d;

  // per-entry payload
  reg_addr_t [`SB_ENTRIES-1:0] rd_q;
  reg_addr_t [`SB_ENTRIES-1:0] rd_d;
  fu_e       [`SB_ENTRIES-1:0] fu_q;
  fu_e       [`SB_ENTRIES-1:0] fu_d;
  xlen_t     [`SB_ENTRIES-1:0] result_q;
  xlen_t     [`SB_ENTRIES-1:0] result_d;

  // writeback only lands on an entry still waiting for it
  logic wb_hit;

  assign wb_hit = wb_valid_i & valid_q[wb_trans_id_i] & ~done_q[wb_trans_id_i];

  // --------------------
  // next table state
  // --------------------
  // steps below run in priority order and the later one wins
  always_comb begin
    valid_d  = valid_q;
    done_d   = done_q;
    ex_d     = ex_q;
    rd_d     = rd_q;
    fu_d     = fu_q;
    result_d = result_q;

    // new instruction from the issue stage
    if (insert_en_i) begin
      valid_d[insert_ptr_i]  = 1'b1;
      done_d[insert_ptr_i]   = 1'b0;
      ex_d[insert_ptr_i]     = 1'b0;
      rd_d[insert_ptr_i]     = decoded_rd_i;
      fu_d[insert_ptr_i]     = decoded_fu_i;
      // result starts at zero and FU_NONE entries keep it
      result_d[insert_ptr_i] = '0;
    end

    // entries without a unit are done as soon as they exist
    for (int e = 0; e < `SB_ENTRIES; e++) begin
      if (valid_d[e] && (fu_d[e] == FU_NONE)) begin
        done_d[e] = 1'b1;
      end
    end

    // result from a functional unit
    if (wb_hit) begin
      done_d[wb_trans_id_i]   = 1'b1;
      ex_d[wb_trans_id_i]     = wb_ex_i;
      result_d[wb_trans_id_i] = wb_data_i;
    end

    // retire the oldest entry
    if (commit_ack_i) begin
      valid_d[commit_ptr_i] = 1'b0;
      done_d[commit_ptr_i]  = 1'b0;
      ex_d[commit_ptr_i]    = 1'b0;
    end

    // flush empties the whole table
    if (flush_i) begin
      valid_d = '0;
      done_d  = '0;
      ex_d    = '0;
    end
  end

  // --------------------
  // table registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      done_q  <= '0;
      ex_q    <= '0;
    end else begin
      valid_q <= valid_d;
      done_q  <= done_d;
      ex_q    <= ex_d;
    end
  end

  // payload written on insert and writeback
  always_ff @(posedge clk_i) begin
    rd_q     <= rd_d;
    fu_q     <= fu_d;
    result_q <= result_d;
  end

  assign valid_o  = valid_q;
  assign done_o   = done_q;
  assign ex_o     = ex_q;
  assign rd_o     = rd_q;
  assign result_o = result_q;

endmodule

/* sb_clobber.sv */
`timescale 1ns/1ps
`include "sb_macros.svh"

module sb_clobber (
  input  sb_pkg::entry_vec_t                  valid_i,
  input  sb_pkg::reg_addr_t [`SB_ENTRIES-1:0] rd_i,
  output sb_pkg::reg_mask_t                   rd_clobber_o
);
  import sb_pkg::*;

  // entries that target each register
  entry_vec_t [`SB_NR_REGS-1:0] hit;

  // --------------------
  // destination match
  // --------------------
  always_comb begin
    hit = '0;
    for (int r = 0; r < `SB_NR_REGS; r++) begin
      for (int e = 0; e < `SB_ENTRIES; e++) begin
        hit[r][e] = valid_i[e] & (rd_i[e] == reg_addr_t'(r));
      end
    end
  end

  // --------------------
  // mask reduction
  // --------------------
  always_comb begin
    rd_clobber_o = '0;
    for (int r = 0; r < `SB_NR_REGS; r++) begin
      rd_clobber_o[r] = |hit[r];
    end
    // writes to x0 have no effect so x0 never shows as pending
    rd_clobber_o[0] = 1'b0;
  end

endmodule

/* sb_operand_fwd.sv */
`timescale 1ns/1ps
`include "sb_macros.svh"

module sb_operand_fwd (
  input  sb_pkg::reg_addr_t                   rs1_i,
  input  sb_pkg::reg_addr_t                   rs2_i,
  input  logic                                wb_valid_i,
  input  logic                                wb_ex_i,
  input  sb_pkg::trans_id_t                   wb_trans_id_i,
  input  sb_pkg::xlen_t                       wb_data_i,
  input  sb_pkg::entry_vec_t                  valid_i,
  input  sb_pkg::entry_vec_t                  done_i,
  input  sb_pkg::reg_addr_t [`SB_ENTRIES-1:0] rd_i,
  input  sb_pkg::xlen_t     [`SB_ENTRIES-1:0] result_i,
  output sb_pkg::xlen_t                       rs1_o,
  output logic                                rs1_valid_o,
  output sb_pkg::xlen_t                       rs2_o,
  output logic                                rs2_valid_o
);
  import sb_pkg::*;

  // source 0 is the writeback port, source e+1 is table entry e
  typedef logic [`SB_ENTRIES:0]   src_vec_t;
  typedef logic [`SB_TRANS_ID_W:0] src_idx_t;

  src_vec_t                src_ok;
  reg_addr_t [`SB_ENTRIES:0] src_rd;
  xlen_t     [`SB_ENTRIES:0] src_data;

  src_vec_t rs1_req;
  src_vec_t rs2_req;

  // lowest set bit wins, so writeback beats every entry
  function automatic src_idx_t first_set(input src_vec_t req);
    src_idx_t idx;
    idx = '0;
    for (int s = `SB_ENTRIES; s >= 0; s--) begin
      if (req[s]) begin
        idx = src_idx_t'(s);
      end
    end
    return idx;
  endfunction

  // --------------------
  // source list
  // --------------------
  always_comb begin
    // a faulting writeback carries no usable result
    src_ok[0]   = wb_valid_i & ~wb_ex_i;
    src_rd[0]   = rd_i[wb_trans_id_i];
    src_data[0] = wb_data_i;
    for (int e = 0; e < `SB_ENTRIES; e++) begin
      src_ok[e+1]   = valid_i[e] & done_i[e];
      src_rd[e+1]   = rd_i[e];
      src_data[e+1] = result_i[e];
    end
  end

  // --------------------
  // requests per operand
  // --------------------
  always_comb begin
    for (int s = 0; s <= `SB_ENTRIES; s++) begin
      rs1_req[s] = src_ok[s] & (src_rd[s] == rs1_i);
      rs2_req[s] = src_ok[s] & (src_rd[s] == rs2_i);
    end
  end

  // data is a don't care while valid is low
  assign rs1_o = src_data[first_set(rs1_req)];
  assign rs2_o = src_data[first_set(rs2_req)];

  // x0 reads as constant zero, never forwarded
  assign rs1_valid_o = (|rs1_req) & (|rs1_i);
  assign rs2_valid_o = (|rs2_req) & (|rs2_i);

endmodule

/* scoreboard_top.sv */
`timescale 1ns/1ps
`include "sb_macros.svh"

module scoreboard_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  // decode and issue
  input  logic              decoded_valid_i,
  input  sb_pkg::reg_addr_t decoded_rd_i,
  input  sb_pkg::fu_e       decoded_fu_i,
  output logic              issue_valid_o,
  output sb_pkg::trans_id_t issue_trans_id_o,
  input  logic              issue_ack_i,
  input  logic              unresolved_branch_i,
  // writeback strobe
  input  logic              wb_valid_i,
  input  sb_pkg::trans_id_t wb_trans_id_i,
  input  sb_pkg::xlen_t     wb_data_i,
  input  logic              wb_ex_i,
  // commit
  output logic              commit_valid_o,
  output logic              commit_done_o,
  output sb_pkg::reg_addr_t commit_rd_o,
  output sb_pkg::xlen_t     commit_result_o,
  output logic              commit_ex_o,
  output sb_pkg::trans_id_t commit_trans_id_o,
  input  logic              commit_ack_i,
  // operand read
  input  sb_pkg::reg_addr_t rs1_i,
  output sb_pkg::xlen_t     rs1_o,
  output logic              rs1_valid_o,
  input  sb_pkg::reg_addr_t rs2_i,
  output sb_pkg::xlen_t     rs2_o,
  output logic              rs2_valid_o,
  // status
  output sb_pkg::reg_mask_t rd_clobber_o,
  input  logic              flush_i,
  output logic              sb_full_o
);
  import sb_pkg::*;

  // control to table
  logic      insert_en;
  trans_id_t insert_ptr;
  trans_id_t commit_ptr;

  // table contents
  entry_vec_t                  entry_valid;
  entry_vec_t                  entry_done;
  entry_vec_t                  entry_ex;
  reg_addr_t [`SB_ENTRIES-1:0] entry_rd;
  xlen_t     [`SB_ENTRIES-1:0] entry_result;

  // --------------------
  // pointers and issue
  // --------------------
  sb_issue_ctrl u_issue_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .decoded_valid_i     (decoded_valid_i),
    .unresolved_branch_i (unresolved_branch_i),
    .issue_ack_i         (issue_ack_i),
    .commit_ack_i        (commit_ack_i),
    .issue_valid_o       (issue_valid_o),
    .insert_en_o         (insert_en),
    .sb_full_o           (sb_full_o),
    .insert_ptr_o        (insert_ptr),
    .commit_ptr_o        (commit_ptr)
  );

  // new entries always land at the insert pointer
  assign issue_trans_id_o = insert_ptr;

  // --------------------
  // entry table
  // --------------------
  sb_entry_store u_entry_store (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .insert_en_i   (insert_en),
    .commit_ack_i  (commit_ack_i),
    .wb_valid_i    (wb_valid_i),
    .wb_ex_i       (wb_ex_i),
    .insert_ptr_i  (insert_ptr),
    .commit_ptr_i  (commit_ptr),
    .wb_trans_id_i (wb_trans_id_i),
    .decoded_rd_i  (decoded_rd_i),
    .decoded_fu_i  (decoded_fu_i),
    .wb_data_i     (wb_data_i),
    .valid_o       (entry_valid),
    .done_o        (entry_done),
    .ex_o          (entry_ex),
    .rd_o          (entry_rd),
    .result_o      (entry_result)
  );

  // oldest entry goes straight to commit
  assign commit_valid_o    = entry_valid[commit_ptr];
  assign commit_done_o     = entry_done[commit_ptr];
  assign commit_ex_o       = entry_ex[commit_ptr];
  assign commit_rd_o       = entry_rd[commit_ptr];
  assign commit_result_o   = entry_result[commit_ptr];
  assign commit_trans_id_o = commit_ptr;

  // --------------------
  // side logic
  // --------------------
  sb_clobber u_clobber (
    .valid_i      (entry_valid),
    .rd_i         (entry_rd),
    .rd_clobber_o (rd_clobber_o)
  );

  sb_operand_fwd u_operand_fwd (
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .wb_valid_i    (wb_valid_i),
    .wb_ex_i       (wb_ex_i),
    .wb_trans_id_i (wb_trans_id_i),
    .wb_data_i     (wb_data_i),
    .valid_i       (entry_valid),
    .done_i        (entry_done),
    .rd_i          (entry_rd),
    .result_i      (entry_result),
    .rs1_o         (rs1_o),
    .rs1_valid_o   (rs1_valid_o),
    .rs2_o         (rs2_o),
    .rs2_valid_o   (rs2_valid_o)
  );

endmodule

/* scoreboard_sva.sv */
`timescale 1ns/1ps

module scoreboard_sva (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              issue_valid_o,
  input logic              issue_ack_i,
  input logic              commit_valid_o,
  input logic              commit_done_o,
  input logic              commit_ack_i,
  input logic              sb_full_o,
  input sb_pkg::reg_mask_t rd_clobber_o
);

  // failed assertions, read by the testbench at the end
  int fail_cnt = 0;

  // --------------------
  // port protocol
  // --------------------
  // x0 never shows a pending write
  clobber_x0_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rd_clobber_o[0])
    else begin
      $error("rd_clobber_o bit 0 is set");
      fail_cnt++;
    end

  // retire only a finished oldest entry
  commit_ack_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_ack_i |-> (commit_valid_o && commit_done_o))
    else begin
      $error("commit_ack_i without a valid, done oldest entry");
      fail_cnt++;
    end

  issue_ack_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_ack_i |-> issue_valid_o)
    else begin
      $error("issue_ack_i while issue_valid_o is low");
      fail_cnt++;
    end

  // full table blocks issue
  full_blocks_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(issue_valid_o && sb_full_o))
    else begin
      $error("issue_valid_o high on a full table");
      fail_cnt++;
    end

endmodule

bind scoreboard_top scoreboard_sva u_sva (.*);

/* tb_scoreboard.sv */
`timescale 1ns/1ps
`include "sb_macros.svh"

module tb_scoreboard;
  import sb_pkg::*;

  localparam int N = `SB_ENTRIES;

  logic      clk_i, rst_ni, flush_i;
  logic      decoded_valid_i, issue_ack_i, unresolved_branch_i;
  logic      wb_valid_i, wb_ex_i, commit_ack_i;
  logic      issue_valid_o, commit_valid_o, commit_done_o, commit_ex_o;
  logic      rs1_valid_o, rs2_valid_o, sb_full_o;
  reg_addr_t decoded_rd_i, commit_rd_o, rs1_i, rs2_i;
  fu_e       decoded_fu_i;
  trans_id_t issue_trans_id_o, wb_trans_id_i, commit_trans_id_o;
  xlen_t     wb_data_i, commit_result_o, rs1_o, rs2_o;
  reg_mask_t rd_clobber_o;

  // reference table, indexed by slot
  logic      m_valid [N];
  logic      m_done  [N];
  logic      m_ex    [N];
  // slot has held an entry, so its rd is known
  logic      m_seen  [N];
  reg_addr_t m_rd    [N];
  xlen_t     m_result[N];
  trans_id_t m_ins_ptr, m_com_ptr;
  // slots in program order, front is oldest
  trans_id_t order_q[$];
  integer    seed;
  int        errors;

  scoreboard_top u_scoreboard_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // {valid, data}: writeback port first, then lowest done entry
  function automatic logic [`SB_XLEN:0] fwd_expect(input reg_addr_t rs);
    if (wb_valid_i && !wb_ex_i && m_rd[wb_trans_id_i] == rs) begin
      return {rs != '0, wb_data_i};
    end
    for (int e = 0; e < N; e++) begin
      if (m_valid[e] && m_done[e] && m_rd[e] == rs) begin
        return {rs != '0, m_result[e]};
      end
    end
    return '0;
  endfunction

  // --------------------
  // output checks
  // --------------------
  task automatic check_outputs();
    trans_id_t         c;
    reg_mask_t         mask;
    logic [`SB_XLEN:0] f1;
    logic [`SB_XLEN:0] f2;
    logic              full;
    c    = m_com_ptr;
    full = (order_q.size() == N - 1);
    mask = '0;
    for (int e = 0; e < N; e++) begin
      if (m_valid[e]) mask[m_rd[e]] = 1'b1;
    end
    mask[0] = 1'b0;
    f1 = fwd_expect(rs1_i);
    f2 = fwd_expect(rs2_i);
    check_value("issue_valid_o", issue_valid_o,
                decoded_valid_i && !unresolved_branch_i && !full);
    check_value("issue_trans_id_o", issue_trans_id_o, m_ins_ptr);
    check_value("sb_full_o", sb_full_o, full);
    check_value("commit_trans_id_o", commit_trans_id_o, c);
    check_value("commit_valid_o", commit_valid_o, m_valid[c]);
    check_value("commit_done_o", commit_done_o, m_done[c]);
    // payload only means something behind valid
    if (m_valid[c]) begin
      check_value("commit_rd_o", commit_rd_o, m_rd[c]);
      check_value("commit_result_o", commit_result_o, m_result[c]);
      check_value("commit_ex_o", commit_ex_o, m_ex[c]);
    end
    check_value("rd_clobber_o", rd_clobber_o, mask);
    check_value("rs1_valid_o", rs1_valid_o, f1[`SB_XLEN]);
    if (f1[`SB_XLEN]) check_value("rs1_o", rs1_o, f1[`SB_XLEN-1:0]);
    check_value("rs2_valid_o", rs2_valid_o, f2[`SB_XLEN]);
    if (f2[`SB_XLEN]) check_value("rs2_o", rs2_o, f2[`SB_XLEN-1:0]);
  endtask

  // --------------------
  // reference model
  // --------------------
  // runs at the edge on the inputs the DUT just sampled
  task automatic update_model();
    logic wb_hit;
    wb_hit = wb_valid_i && m_valid[wb_trans_id_i] && !m_done[wb_trans_id_i];
    if (flush_i) begin
      // acks in a flush cycle are lost
      foreach (m_valid[i]) begin
        m_valid[i] = 1'b0;
        m_done[i]  = 1'b0;
        m_ex[i]    = 1'b0;
      end
      m_ins_ptr = '0;
      m_com_ptr = '0;
      order_q.delete();
    end else begin
      if (wb_hit) begin
        m_done[wb_trans_id_i]   = 1'b1;
        m_ex[wb_trans_id_i]     = wb_ex_i;
        m_result[wb_trans_id_i] = wb_data_i;
      end
      if (issue_ack_i) begin
        m_valid[m_ins_ptr]  = 1'b1;
        m_done[m_ins_ptr]   = (decoded_fu_i == FU_NONE);
        m_ex[m_ins_ptr]     = 1'b0;
        m_rd[m_ins_ptr]     = decoded_rd_i;
        m_result[m_ins_ptr] = '0;
        m_seen[m_ins_ptr]   = 1'b1;
        order_q.push_back(m_ins_ptr);
        m_ins_ptr++;
      end
      if (commit_ack_i) begin
        m_valid[m_com_ptr] = 1'b0;
        m_done[m_com_ptr]  = 1'b0;
        m_ex[m_com_ptr]    = 1'b0;
        void'(order_q.pop_front());
        m_com_ptr++;
      end
    end
  endtask

  task automatic idle_inputs();
    {decoded_valid_i, issue_ack_i, unresolved_branch_i, flush_i} = '0;
    {wb_valid_i, wb_ex_i, commit_ack_i} = '0;
    decoded_rd_i  = '0;
    decoded_fu_i  = FU_ALU;
    wb_trans_id_i = '0;
    wb_data_i     = '0;
    rs1_i         = '0;
    rs2_i         = '0;
  endtask

  task automatic drive_random();
    logic [31:0] r1;
    logic [31:0] r3;
    trans_id_t   slot;
    r1 = $random(seed);
    r3 = $random(seed);
    decoded_valid_i     = r1[0] | r1[1];
    unresolved_branch_i = (r1[3:2] == 2'b00);
    decoded_rd_i        = r1[8:4];
    decoded_fu_i        = fu_e'(r1[10:9]);
    issue_ack_i = decoded_valid_i && !unresolved_branch_i && order_q.size() < N - 1 && r1[11];
    // mostly slots still waiting, now and then a stale or finished one
    slot          = r1[14:12];
    wb_trans_id_i = slot;
    wb_valid_i    = m_seen[slot] &&
                    ((m_valid[slot] && !m_done[slot]) ? r1[15] : (r1[17:16] == 2'b00));
    wb_ex_i       = (r1[20:18] == 3'b000);
    wb_data_i     = $random(seed);
    commit_ack_i  = m_valid[m_com_ptr] && m_done[m_com_ptr] && r1[21];
    flush_i       = (r1[27:22] == 6'd0);
    // half the reads aim at a destination in the table
    rs1_i = r3[0] ? m_rd[r3[3:1]] : r3[8:4];
    rs2_i = r3[9] ? m_rd[r3[12:10]] : r3[17:13];
  endtask

  // check mid-cycle, then advance model and DUT together
  task automatic run_cycle();
    @(negedge clk_i);
    check_outputs();
    @(posedge clk_i);
    update_model();
    #1;
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial begin
    int waited;
    int inserts;
    seed   = 39;
    errors = 0;
    rst_ni = 1'b0;
    idle_inputs();
    foreach (m_valid[i]) begin
      {m_valid[i], m_done[i], m_ex[i], m_seen[i]} = '0;
      m_rd[i]     = '0;
      m_result[i] = '0;
    end
    m_ins_ptr = '0;
    m_com_ptr = '0;
    repeat (4) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    repeat (3000) begin
      drive_random();
      run_cycle();
    end

    // flush, then a writeback into the emptied slot 0
    idle_inputs();
    flush_i = 1'b1;
    run_cycle();
    idle_inputs();
    wb_valid_i = m_seen[0];
    wb_data_i  = 32'hdead_beef;
    run_cycle();
    check_value("commit_valid_o", commit_valid_o, 1'b0);
    check_value("sb_full_o", sb_full_o, 1'b0);
    check_value("rd_clobber_o", rd_clobber_o, '0);

    // fill without commits until the DUT reports full
    idle_inputs();
    decoded_valid_i = 1'b1;
    inserts = 0;
    waited  = 0;
    while (!sb_full_o && waited < 4 * N) begin
      decoded_rd_i = reg_addr_t'(waited + 1);
      issue_ack_i  = (order_q.size() < N - 1);
      inserts      = inserts + issue_ack_i;
      run_cycle();
      waited++;
    end
    if (!sb_full_o) begin
      $display("timeout waiting for sb_full_o while filling the table");
      errors++;
    end
    check_value("inserts until sb_full_o", inserts, N - 1);

    // drain, writing back each oldest entry before retiring it
    waited = 0;
    while (commit_valid_o && waited < 4 * N) begin
      idle_inputs();
      if (commit_done_o) begin
        commit_ack_i = 1'b1;
      end else begin
        wb_valid_i    = 1'b1;
        wb_trans_id_i = commit_trans_id_o;
        wb_data_i     = $random(seed);
      end
      rs1_i = reg_addr_t'(waited);
      run_cycle();
      waited++;
    end
    if (commit_valid_o) begin
      $display("timeout waiting for the table to drain");
      errors++;
    end

    $display("check errors: %0d, assertion errors: %0d", errors,
             u_scoreboard_top.u_sva.fail_cnt);
    if (errors == 0 && u_scoreboard_top.u_sva.fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+.
sb_pkg.sv
sb_issue_ctrl.sv
sb_entry_store.sv
sb_clobber.sv
sb_operand_fwd.sv
scoreboard_top.sv
scoreboard_sva.sv
tb_scoreboard.sv
